//--- filelist.f
rtl/l2_ret_pkg.sv
rtl/l2_apb_pkg.sv
rtl/sctag_data_store.sv
rtl/sctag_retdp.sv
rtl/sctag_ecc_correct.sv
rtl/sctag_apb_ctl.sv
rtl/l2_ret_top.sv
testbench/tb_l2_ret.sv

//--- rtl/l2_apb_pkg.sv
// APB interface with 8-bit address and 32-bit data, word aligned registers only
`default_nettype none

package l2_apb_pkg;

   // Host to slave
   typedef struct packed {
      logic [7:0]  paddr;
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [31:0] pwdata;
   } apb_req_t;

   // Slave to host
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // Register map
   typedef enum logic [7:0] {
      CTRL   = 8'h00,
      STATUS = 8'h04,
      INJECT = 8'h08,
      WDATA0 = 8'h10,
      WDATA1 = 8'h14,
      WDATA2 = 8'h18,
      WDATA3 = 8'h1C,
      RDATA0 = 8'h20,
      RDATA1 = 8'h24,
      RDATA2 = 8'h28,
      RDATA3 = 8'h2C
   } reg_addr_e;

   // Stage holding the read word
   typedef enum logic [1:0] {
      IDLE,
      READ_C6,
      READ_C7,
      READ_C8
   } ctl_state_e;

endpackage

`default_nettype wire

//--- rtl/l2_ret_pkg.sv
// Line geometry is fixed at four 32-bit lanes with 7 SEC-DED check bits each (156-bit array word)
`default_nettype none

package l2_ret_pkg;

   // Line geometry
   localparam int LANES       = 4;
   localparam int LANE_DATA_W = 32;
   localparam int LANE_ECC_W  = 7;
   localparam int LANE_GRP_W  = LANE_DATA_W + LANE_ECC_W;
   localparam int LINE_DATA_W = LANES * LANE_DATA_W;
   localparam int LINE_ECC_W  = LANES * LANE_ECC_W;
   localparam int LINE_W      = LINE_DATA_W + LINE_ECC_W;

   // Return datapath output, data and check bits in separate fields
   typedef struct packed {
      logic [LINE_DATA_W-1:0] data;
      logic [LINE_ECC_W-1:0]  ecc;
   } ret_line_t;

   // One bit per lane
   typedef struct packed {
      logic [LANES-1:0] ce;
      logic [LANES-1:0] ue;
   } ecc_status_t;

   // Syndrome of one lane
   typedef struct packed {
      logic [5:0] syn;
      logic       mismatch;
   } lane_syn_t;

   // Hamming bits over codeword positions 1..38, data skips the powers of two
   function automatic logic [LANE_ECC_W-1:0] ecc_encode_lane(input logic [LANE_DATA_W-1:0] d);
      logic [5:0] h;
      int         j;
      h = '0;
      j = 0;
      for (int pos = 1; pos <= LANE_GRP_W - 1; pos++) begin
         if ((pos & (pos - 1)) != 0) begin
            for (int i = 0; i < 6; i++) begin
               if (pos[i]) h[i] = h[i] ^ d[j];
            end
            j++;
         end
      end
      // Overall even parity in bit 6
      return {(^d) ^ (^h), h};
   endfunction

   // Zero syndrome and no mismatch for a clean lane
   function automatic lane_syn_t ecc_syndrome_lane(input logic [LANE_DATA_W-1:0] d,
                                                  input logic [LANE_ECC_W-1:0]  c);
      logic [LANE_ECC_W-1:0] recalc;
      lane_syn_t             s;
      recalc     = ecc_encode_lane(d);
      s.syn      = recalc[5:0] ^ c[5:0];
      s.mismatch = ^{d, c};
      return s;
   endfunction

endpackage

`default_nettype wire

//--- rtl/l2_ret_top.sv
// Read result appears in STATUS and RDATA 4 cycles after the CTRL access edge
`timescale 1ns/1ps
`default_nettype none

module l2_ret_top #(
   parameter int DEPTH = 16
) (
   input  wire                    rclk,
   input  wire                    reset,
   input  l2_apb_pkg::apb_req_t   apb_req,
   output l2_apb_pkg::apb_rsp_t   apb_rsp
);

   import l2_ret_pkg::*;

   // Array ports
   logic                     wr_en;
   logic [$clog2(DEPTH)-1:0] wr_index;
   logic [LINE_W-1:0]        wr_line;
   logic                     rd_en;
   logic [$clog2(DEPTH)-1:0] rd_index;

   // Pipeline stages
   logic [LINE_W-1:0]        rd_line_c6;
   ret_line_t                ret_c7;
   logic [LINE_DATA_W-1:0]   data_c8;
   ecc_status_t              status_c8;

   sctag_apb_ctl #(.DEPTH(DEPTH)) i_ctl (
      .rclk      (rclk),
      .reset     (reset),
      .apb_req   (apb_req),
      .data_c8   (data_c8),
      .status_c8 (status_c8),
      .apb_rsp   (apb_rsp),
      .wr_en     (wr_en),
      .wr_index  (wr_index),
      .wr_line   (wr_line),
      .rd_en     (rd_en),
      .rd_index  (rd_index)
   );

   sctag_data_store #(.DEPTH(DEPTH)) i_store (
      .rclk       (rclk),
      .wr_en      (wr_en),
      .wr_index   (wr_index),
      .wr_line    (wr_line),
      .rd_en      (rd_en),
      .rd_index   (rd_index),
      .rd_line_c6 (rd_line_c6)
   );

   sctag_retdp i_retdp (
      .rclk    (rclk),
      .reset   (reset),
      .decc_c6 (rd_line_c6),
      .ret_c7  (ret_c7)
   );

   sctag_ecc_correct i_ecc (
      .rclk      (rclk),
      .reset     (reset),
      .ret_c7    (ret_c7),
      .data_c8   (data_c8),
      .status_c8 (status_c8)
   );

endmodule

`default_nettype wire

//--- rtl/sctag_apb_ctl.sv
// DEPTH up to 16 (index in CTRL bits 7:4), no wait states, one read in flight at a time
`timescale 1ns/1ps
`default_nettype none

module sctag_apb_ctl #(
   parameter int DEPTH = 16
) (
   input  wire                                  rclk,
   input  wire                                  reset,
   input  l2_apb_pkg::apb_req_t                 apb_req,
   input  wire  [l2_ret_pkg::LINE_DATA_W-1:0]   data_c8,
   input  l2_ret_pkg::ecc_status_t              status_c8,
   output l2_apb_pkg::apb_rsp_t                 apb_rsp,
   output logic                                 wr_en,
   output logic [$clog2(DEPTH)-1:0]             wr_index,
   output logic [l2_ret_pkg::LINE_W-1:0]        wr_line,
   output logic                                 rd_en,
   output logic [$clog2(DEPTH)-1:0]             rd_index
);

   import l2_ret_pkg::*;
   import l2_apb_pkg::*;

   localparam int IW = $clog2(DEPTH);

   // Registers
   logic [LANES-1:0][LANE_DATA_W-1:0] wdata_q;
   logic [LANES-1:0][LANE_DATA_W-1:0] rdata_q;
   logic [15:0]                       inject_q;
   ecc_status_t                       status_q;
   logic                              done;
   logic [31:0]                       prdata_q;
   ctl_state_e                        state;

   // Bus decode
   reg_addr_e   addr;
   logic        access;
   logic        setup;
   logic        addr_ok;
   logic        wdata_sel;
   logic [31:0] rd_mux;
   logic        busy;
   logic        ctrl_wr;
   logic        ctrl_err;
   logic        fill_go;
   logic        read_go;

   // Fill line build
   logic [LINE_W-1:0] enc_line;
   logic [LINE_W-1:0] inj_mask;
   int                base;

   assign addr   = reg_addr_e'(apb_req.paddr);
   assign access = apb_req.psel & apb_req.penable;
   assign setup  = apb_req.psel & ~apb_req.penable;
   assign busy   = rd_en | (state != IDLE);

   // Address check and read data mux
   always_comb begin
      addr_ok   = 1'b1;
      wdata_sel = 1'b0;
      rd_mux    = '0;
      case (addr)
         CTRL:   rd_mux[4 +: IW] = rd_index;
         STATUS: rd_mux = {16'h0, status_q.ue, status_q.ce, 6'h0, busy, done};
         INJECT: rd_mux = {16'h0, inject_q};
         WDATA0, WDATA1, WDATA2, WDATA3: begin
            wdata_sel = 1'b1;
            rd_mux    = wdata_q[apb_req.paddr[3:2]];
         end
         RDATA0, RDATA1, RDATA2, RDATA3: rd_mux = rdata_q[apb_req.paddr[3:2]];
         default: addr_ok = 1'b0;
      endcase
   end

   // Command strobes, only one of fill and read per write
   assign ctrl_wr  = access & apb_req.pwrite & (addr == CTRL);
   assign ctrl_err = ctrl_wr & (busy | (apb_req.pwdata[0] & apb_req.pwdata[1]));
   assign fill_go  = ctrl_wr & ~ctrl_err & apb_req.pwdata[0];
   assign read_go  = ctrl_wr & ~ctrl_err & apb_req.pwdata[1];

   assign apb_rsp.prdata  = prdata_q;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access & (~addr_ok | ctrl_err);

   // Encode each lane as {data, check bits}
   always_comb begin
      for (int k = 0; k < LANES; k++) begin
         enc_line[k*LANE_GRP_W +: LANE_GRP_W] = {wdata_q[k], ecc_encode_lane(wdata_q[k])};
      end
   end

   // Up to two flips inside the selected lane group
   always_comb begin
      inj_mask = '0;
      base     = int'(inject_q[1:0]) * LANE_GRP_W;
      if (inject_q[8] && (int'(inject_q[7:2]) < LANE_GRP_W)) begin
         inj_mask[base + int'(inject_q[7:2])] = 1'b1;
      end
      if (inject_q[15] && (int'(inject_q[14:9]) < LANE_GRP_W)) begin
         inj_mask[base + int'(inject_q[14:9])] = 1'b1;
      end
   end

   // Array write lands on the CTRL access edge
   assign wr_en    = fill_go;
   assign wr_index = apb_req.pwdata[4 +: IW];
   assign wr_line  = enc_line ^ inj_mask;

   // Read data is set up ahead of the access phase
   always_ff @(posedge rclk) begin
      if (reset) begin
         prdata_q <= '0;
      end else if (setup && !apb_req.pwrite) begin
         prdata_q <= rd_mux;
      end
   end

   // Host write data words
   always_ff @(posedge rclk) begin
      if (access && apb_req.pwrite && wdata_sel) begin
         wdata_q[apb_req.paddr[3:2]] <= apb_req.pwdata;
      end
   end

   // Injection mask is consumed by one fill
   always_ff @(posedge rclk) begin
      if (reset) begin
         inject_q <= '0;
      end else if (fill_go) begin
         inject_q <= '0;
      end else if (access && apb_req.pwrite && (addr == INJECT)) begin
         inject_q <= apb_req.pwdata[15:0];
      end
   end

   // Read sequencing, state names the stage whose word is valid
   always_ff @(posedge rclk) begin
      if (reset) begin
         state    <= IDLE;
         rd_en    <= 1'b0;
         rd_index <= '0;
         done     <= 1'b0;
         status_q <= '0;
      end else begin
         rd_en <= read_go;
         if (read_go) begin
            rd_index <= apb_req.pwdata[4 +: IW];
            done     <= 1'b0;
         end
         case (state)
            IDLE:    if (rd_en) state <= READ_C6;
            READ_C6: state <= READ_C7;
            READ_C7: state <= READ_C8;
            READ_C8: begin
               state    <= IDLE;
               done     <= 1'b1;
               status_q <= status_c8;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Corrected line capture
   always_ff @(posedge rclk) begin
      if (state == READ_C8) begin
         rdata_q <= data_c8;
      end
   end

endmodule

`default_nettype wire

//--- rtl/sctag_data_store.sv
// No reset on the array, a read and a write to the same index in one cycle return the old word
`timescale 1ns/1ps
`default_nettype none

module sctag_data_store #(
   parameter int DEPTH = 16
) (
   input  wire                               rclk,
   input  wire                               wr_en,
   input  wire  [$clog2(DEPTH)-1:0]          wr_index,
   input  wire  [l2_ret_pkg::LINE_W-1:0]     wr_line,
   input  wire                               rd_en,
   input  wire  [$clog2(DEPTH)-1:0]          rd_index,
   output logic [l2_ret_pkg::LINE_W-1:0]     rd_line_c6
);

   import l2_ret_pkg::*;

   // Line storage
   logic [LINE_W-1:0] mem [DEPTH];

   // Fill port
   always_ff @(posedge rclk) begin
      if (wr_en) begin
         mem[wr_index] <= wr_line;
      end
   end

   // Registered read, holds its word between reads
   always_ff @(posedge rclk) begin
      if (rd_en) begin
         rd_line_c6 <= mem[rd_index];
      end
   end

endmodule

`default_nettype wire

//--- rtl/sctag_ecc_correct.sv
// Corrects one flipped bit per lane and flags two; three or more flips are not detected reliably
`timescale 1ns/1ps
`default_nettype none

module sctag_ecc_correct (
   input  wire                                  rclk,
   input  wire                                  reset,
   input  l2_ret_pkg::ret_line_t                ret_c7,
   output logic [l2_ret_pkg::LINE_DATA_W-1:0]   data_c8,
   output l2_ret_pkg::ecc_status_t              status_c8
);

   import l2_ret_pkg::*;

   // Per-lane working values
   lane_syn_t              syn   [LANES];
   logic [LANE_DATA_W-1:0] lane_d;
   logic [LANE_ECC_W-1:0]  lane_c;
   int                     j;

   // Corrected result, still in c7
   logic [LINE_DATA_W-1:0] data_c7;
   ecc_status_t            status_c7;

   always_comb begin
      data_c7   = '0;
      status_c7 = '0;
      lane_d    = '0;
      lane_c    = '0;
      j         = 0;
      for (int k = 0; k < LANES; k++) begin
         lane_d = ret_c7.data[k*LANE_DATA_W +: LANE_DATA_W];
         lane_c = ret_c7.ecc[k*LANE_ECC_W +: LANE_ECC_W];
         syn[k] = ecc_syndrome_lane(lane_d, lane_c);

         // Single error, flip the data bit at the syndrome position
         if (syn[k].mismatch) begin
            status_c7.ce[k] = 1'b1;
            j = 0;
            for (int pos = 1; pos <= LANE_GRP_W - 1; pos++) begin
               if ((pos & (pos - 1)) != 0) begin
                  if (int'(syn[k].syn) == pos) lane_d[j] = ~lane_d[j];
                  j++;
               end
            end
         end

         // Even number of flips with nonzero syndrome
         else if (syn[k].syn != '0) begin
            status_c7.ue[k] = 1'b1;
         end

         data_c7[k*LANE_DATA_W +: LANE_DATA_W] = lane_d;
      end
   end

   // Stage c8
   always_ff @(posedge rclk) begin
      if (reset) begin
         data_c8   <= '0;
         status_c8 <= '0;
      end else begin
         data_c8   <= data_c7;
         status_c8 <= status_c7;
      end
   end

endmodule

`default_nettype wire

//--- rtl/sctag_retdp.sv
// Lane groups are {data, ecc} at 39-bit strides, one cycle of latency into c7
`timescale 1ns/1ps
`default_nettype none

module sctag_retdp (
   input  wire                              rclk,
   input  wire                              reset,
   input  wire  [l2_ret_pkg::LINE_W-1:0]    decc_c6,
   output l2_ret_pkg::ret_line_t            ret_c7
);

   import l2_ret_pkg::*;

   // Unpacked array word, still in c6
   ret_line_t ret_c6;

   // Data sits above the check bits inside each lane group
   always_comb begin
      for (int k = 0; k < LANES; k++) begin
         ret_c6.data[k*LANE_DATA_W +: LANE_DATA_W] =
            decc_c6[k*LANE_GRP_W + LANE_ECC_W +: LANE_DATA_W];
         ret_c6.ecc[k*LANE_ECC_W +: LANE_ECC_W]    = decc_c6[k*LANE_GRP_W +: LANE_ECC_W];
      end
   end

   // Stage c7
   always_ff @(posedge rclk) begin
      if (reset) begin
         ret_c7 <= '0;
      end else begin
         ret_c7 <= ret_c6;
      end
   end

endmodule

`default_nettype wire

//--- testbench/l2_ret_input.txt
// op idx wdata0 wdata1 wdata2 wdata3 inject rdata0 rdata1 rdata2 rdata3 ce ue
// op bit 0 fills the line, bit 1 reads it back and checks, op 0 ends the list
3 0 01234567 89ABCDEF FEDCBA98 76543210 0000 01234567 89ABCDEF FEDCBA98 76543210 0 0
3 F DEADBEEF CAFEF00D 0BADC0DE 12345678 0000 DEADBEEF CAFEF00D 0BADC0DE 12345678 0 0
3 7 00000000 FFFFFFFF A5A5A5A5 5A5A5A5A 0000 00000000 FFFFFFFF A5A5A5A5 5A5A5A5A 0 0
// single data bit flips, one per lane
3 2 CAFEBABE 00C0FFEE 8BADF00D FEEDFACE 011C CAFEBABE 00C0FFEE 8BADF00D FEEDFACE 1 0
3 3 0A0B0C0D 1A1B1C1D 2A2B2C2D 3A3B3C3D 0199 0A0B0C0D 1A1B1C1D 2A2B2C2D 3A3B3C3D 2 0
3 4 80000001 40000002 20000004 10000008 0152 80000001 40000002 20000004 10000008 4 0
3 5 FFFF0000 0000FFFF F0F0F0F0 0F0F0F0F 017F FFFF0000 0000FFFF F0F0F0F0 0F0F0F0F 8 0
// check bit and overall parity bit flips
3 6 13579BDF 2468ACE0 FDB97531 0ECA8642 0108 13579BDF 2468ACE0 FDB97531 0ECA8642 1 0
3 8 AAAAAAAA 55555555 CCCCCCCC 33333333 011B AAAAAAAA 55555555 CCCCCCCC 33333333 8 0
3 C 76543210 FEDCBA98 89ABCDEF 01234567 0115 76543210 FEDCBA98 89ABCDEF 01234567 2 0
// double flips, data left with both flips
3 9 11111111 22222222 33333333 44444444 991E 11111111 22222222 33333312 44444444 0 4
3 A 89ABCDEF 01234567 76543210 FEDCBA98 CD2C 09ABCDFF 01234567 76543210 FEDCBA98 0 1
3 B 00000000 FFFFFFFF 0F0F0F0F 13579BDF 8347 00000000 FFFFFFFF 0F0F0F0F 13579FDF 0 8
// clean fill right after an injected one
3 1 BEEFCAFE 0D15EA5E 600DF00D FACEB00C 0000 BEEFCAFE 0D15EA5E 600DF00D FACEB00C 0 0
// read back earlier lines
2 0 00000000 00000000 00000000 00000000 0000 01234567 89ABCDEF FEDCBA98 76543210 0 0
2 F 00000000 00000000 00000000 00000000 0000 DEADBEEF CAFEF00D 0BADC0DE 12345678 0 0
2 9 00000000 00000000 00000000 00000000 0000 11111111 22222222 33333312 44444444 0 4
0 0 00000000 00000000 00000000 00000000 0000 00000000 00000000 00000000 00000000 0 0

//--- testbench/tb_l2_ret.sv
// Run from the project root so testbench/l2_ret_input.txt is found, stops at the first error
`timescale 1ns/1ps
`default_nettype none

module tb_l2_ret;

   import l2_apb_pkg::*;

   localparam int DEPTH      = 16;
   localparam int CLK_PERIOD = 40;
   localparam int REC_W      = 13;
   localparam int MAX_REC    = 32;
   localparam int POLL_MAX   = 8;

   logic     rclk;
   logic     reset;
   apb_req_t apb_req;
   apb_rsp_t apb_rsp;

   // Records of 13 words, see the column line in the data file
   logic [31:0] recs [REC_W*MAX_REC];
   int          n_rec;
   logic        loaded;
   integer      seed;

   l2_ret_top #(.DEPTH(DEPTH)) i_dut (
      .rclk    (rclk),
      .reset   (reset),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp)
   );

   initial rclk = 1'b0;
   always #(CLK_PERIOD / 2) rclk = ~rclk;

   task automatic end_with_failure();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped after an error");
   endtask

   task automatic compare_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp) else begin
         $display("CHECK FAILED at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   // Setup phase, access phase, then back to idle; pslverr sampled mid access phase
   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
      @(posedge rclk);
      apb_req.paddr   <= addr;
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= 1'b1;
      apb_req.pwdata  <= data;
      @(posedge rclk);
      apb_req.penable <= 1'b1;
      @(negedge rclk);
      compare_word(apb_rsp.pready, 1, $sformatf("pready on write to %02h", addr));
      compare_word(apb_rsp.pslverr, exp_err, $sformatf("pslverr on write to %02h", addr));
      @(posedge rclk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
      @(posedge rclk);
      apb_req.paddr   <= addr;
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= 1'b0;
      @(posedge rclk);
      apb_req.penable <= 1'b1;
      @(negedge rclk);
      compare_word(apb_rsp.pready, 1, $sformatf("pready on read of %02h", addr));
      compare_word(apb_rsp.pslverr, exp_err, $sformatf("pslverr on read of %02h", addr));
      data = apb_rsp.prdata;
      @(posedge rclk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   // INJECT written only when nonzero, so clean fills rely on its self clear
   task automatic fill_line(input logic [3:0] idx, input logic [3:0][31:0] words,
                            input logic [15:0] inject);
      if (inject != '0) write_reg(INJECT, {16'h0, inject}, 1'b0);
      for (int k = 0; k < 4; k++) begin
         write_reg(8'(8'h10 + 4 * k), words[k], 1'b0);
      end
      write_reg(CTRL, {24'h0, idx, 4'b0001}, 1'b0);
   endtask

   // Poll STATUS for done, then fetch the corrected words; status is {ue, ce}
   task automatic collect_result(output logic [3:0][31:0] words, output logic [7:0] status);
      logic [31:0] st;
      int          polls;
      st    = '0;
      polls = 0;
      while (!st[0]) begin
         if (polls == POLL_MAX) begin
            $display("Read result never showed done in STATUS");
            end_with_failure();
         end
         read_reg(STATUS, st, 1'b0);
         polls++;
      end
      for (int k = 0; k < 4; k++) begin
         read_reg(8'(8'h20 + 4 * k), words[k], 1'b0);
      end
      status = st[15:8];
   endtask

   task automatic read_line(input logic [3:0] idx, output logic [3:0][31:0] words,
                            output logic [7:0] status);
      write_reg(CTRL, {24'h0, idx, 4'b0010}, 1'b0);
      collect_result(words, status);
   endtask

   task automatic run_record(input int r);
      int               b;
      logic [3:0][31:0] wd;
      logic [3:0][31:0] got;
      logic [7:0]       stat;
      b = r * REC_W;
      for (int k = 0; k < 4; k++) begin
         wd[k] = recs[b + 2 + k];
      end
      if (recs[b][0]) fill_line(recs[b + 1][3:0], wd, recs[b + 6][15:0]);
      if (recs[b][1]) begin
         read_line(recs[b + 1][3:0], got, stat);
         for (int k = 0; k < 4; k++) begin
            compare_word(got[k], recs[b + 7 + k], $sformatf("record %0d RDATA%0d", r, k));
         end
         compare_word(stat[3:0], recs[b + 11], $sformatf("record %0d ce", r));
         compare_word(stat[7:4], recs[b + 12], $sformatf("record %0d ue", r));
      end
   endtask

   task automatic check_timing_and_errors();
      logic [3:0][31:0] t_words;
      logic [3:0][31:0] got;
      logic [7:0]       stat;
      logic [31:0]      st;
      t_words = {32'hC3D2E1F0, 32'h8796A5B4, 32'h4B5A6978, 32'h0F1E2D3C};
      fill_line(4'hD, t_words, 16'h0);
      // STATUS read sampled after edge 3, still busy
      write_reg(CTRL, 32'hD2, 1'b0);
      repeat (2) @(posedge rclk);
      read_reg(STATUS, st, 1'b0);
      compare_word(st[1:0], 2'b10, "busy and done 3 cycles after read start");
      // Sampled after edge 4, done
      write_reg(CTRL, 32'hD2, 1'b0);
      repeat (3) @(posedge rclk);
      read_reg(STATUS, st, 1'b0);
      compare_word(st[1:0], 2'b01, "busy and done 4 cycles after read start");
      // Fill while a read is in flight must be dropped
      write_reg(WDATA0, 32'hFFFF_FFFF, 1'b0);
      write_reg(CTRL, 32'hD2, 1'b0);
      write_reg(CTRL, 32'hD1, 1'b1);
      collect_result(got, stat);
      for (int k = 0; k < 4; k++) begin
         compare_word(got[k], t_words[k], $sformatf("RDATA%0d after busy CTRL", k));
      end
      compare_word(stat, 8'h00, "ce and ue after busy CTRL");
      read_line(4'hD, got, stat);
      compare_word(got[0], t_words[0], "line kept after dropped fill");
      // Unmapped addresses and both command bits
      write_reg(8'h30, 32'h1234_5678, 1'b1);
      read_reg(8'h40, st, 1'b1);
      write_reg(CTRL, 32'hE3, 1'b1);
      read_reg(STATUS, st, 1'b0);
      compare_word(st[15:0], 16'h0001, "STATUS after rejected accesses");
      for (int k = 0; k < 4; k++) begin
         read_reg(8'(8'h20 + 4 * k), st, 1'b0);
         compare_word(st, t_words[k], $sformatf("RDATA%0d after rejected accesses", k));
      end
   endtask

   // Every line with seeded random data, read back clean
   task automatic run_bulk_pass();
      logic [3:0][31:0] words [DEPTH];
      logic [3:0][31:0] got;
      logic [7:0]       stat;
      for (int i = 0; i < DEPTH; i++) begin
         for (int k = 0; k < 4; k++) begin
            words[i][k] = $random(seed);
         end
         fill_line(i[3:0], words[i], 16'h0);
      end
      for (int i = 0; i < DEPTH; i++) begin
         read_line(i[3:0], got, stat);
         for (int k = 0; k < 4; k++) begin
            compare_word(got[k], words[i][k], $sformatf("bulk line %0d word %0d", i, k));
         end
         compare_word(stat, 8'h00, $sformatf("bulk line %0d status", i));
      end
   endtask

   initial begin
      apb_req = '0;
      reset   = 1'b1;
      loaded  = 1'b0;
      seed    = 17;
      n_rec   = 0;
      $readmemh("testbench/l2_ret_input.txt", recs);
      // Op 0 ends the list
      while (n_rec < MAX_REC && recs[n_rec * REC_W] !== 32'h0) begin
         if ($isunknown(recs[n_rec * REC_W])) begin
            $display("Stimulus file missing or unreadable at record %0d", n_rec);
            end_with_failure();
         end
         n_rec++;
      end
      if (n_rec == 0 || n_rec == MAX_REC) begin
         $display("Stimulus file has no records or no end record");
         end_with_failure();
      end
      loaded = 1'b1;
      repeat (5) @(posedge rclk);
      reset <= 1'b0;
      for (int r = 0; r < n_rec; r++) begin
         run_record(r);
      end
      check_timing_and_errors();
      run_bulk_pass();
      $display("*** PASSED ***");
      $finish;
   end

   // 40 cycles per record and per bulk fill or read, plus room for reset and fixed checks
   initial begin
      longint wd_cycles;
      wait (loaded);
      wd_cycles = (longint'(n_rec) + 2 * DEPTH) * 40 + 400;
      #(wd_cycles * CLK_PERIOD);
      $display("Watchdog expired, the simulation timed out before all tests finished");
      end_with_failure();
   end

endmodule

`default_nettype wire
